// File: rrf_pkg.sv
// rrf shared definitions: address width, entry count, tile split and address type
`default_nettype none

package rrf_pkg;

  // architectural register address
  localparam int RRF_ADDR_WIDTH = 5;

  // number of architectural entries held
  localparam int RRF_ENTRIES = 32;

  // entries per tile for the read mux split
  localparam int RRF_TILE_ENTRIES = 16;

  // tile count, derived from the split above
  localparam int RRF_TILES = RRF_ENTRIES / RRF_TILE_ENTRIES;

  // low address bits that pick an entry inside a tile
  localparam int RRF_IDX_WIDTH = $clog2(RRF_TILE_ENTRIES);

  // upper address bits that pick the tile
  localparam int RRF_TILE_SEL_WIDTH = RRF_ADDR_WIDTH - RRF_IDX_WIDTH;

  // unsigned register address
  typedef logic [RRF_ADDR_WIDTH-1:0] rrf_addr_t;

endpackage

`default_nettype wire

// File: rrf_write_decode.sv
// rrf write decoder: maps the two retire write ports onto per-entry enables, port 1 first
`timescale 1ns/1ps
`default_nettype none

module rrf_write_decode
  import rrf_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)
(
  input  wire rrf_addr_t                 write0_addr,
  input  wire logic [DATA_WIDTH-1:0]     write0_data,
  input  wire logic                      write0_wen,
  input  wire rrf_addr_t                 write1_addr,
  input  wire logic [DATA_WIDTH-1:0]     write1_data,
  input  wire logic                      write1_wen,
  output logic      [RRF_ENTRIES-1:0]    entry_wen,
  output logic      [RRF_ENTRIES-1:0]    entry_sel1,
  output logic      [DATA_WIDTH-1:0]     wdata0,
  output logic      [DATA_WIDTH-1:0]     wdata1
);

  logic [RRF_ENTRIES-1:0] hit0; // one-hot, port 0
  logic [RRF_ENTRIES-1:0] hit1; // one-hot, port 1

  // one-hot decode of each enabled port
  always_comb
  begin
    hit0 = '0;
    hit1 = '0;
    if (write0_wen)
    begin
      hit0 = RRF_ENTRIES'(1) << write0_addr;
    end
    if (write1_wen)
    begin
      hit1 = RRF_ENTRIES'(1) << write1_addr;
    end
  end

  // an entry is written when either port hits it
  assign entry_wen = hit0 | hit1;

  // port 1 takes the entry on a collision
  assign entry_sel1 = hit1;

  // data words, quiet while the port is idle
  always_comb
  begin
    wdata0 = '0;
    wdata1 = '0;
    if (write0_wen)
    begin
      wdata0 = write0_data;
    end
    if (write1_wen)
    begin
      wdata1 = write1_data;
    end
  end

endmodule

`default_nettype wire

// File: rrf_entry_bank.sv
// rrf entry bank: 32 architectural registers loaded from the selected write word
`timescale 1ns/1ps
`default_nettype none

module rrf_entry_bank
  import rrf_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)
(
  input  wire logic                              clk,
  input  wire logic                              rst,
  input  wire logic [RRF_ENTRIES-1:0]            entry_wen,
  input  wire logic [RRF_ENTRIES-1:0]            entry_sel1,
  input  wire logic [DATA_WIDTH-1:0]             wdata0,
  input  wire logic [DATA_WIDTH-1:0]             wdata1,
  output logic      [RRF_ENTRIES*DATA_WIDTH-1:0] entries_flat
);

  logic [DATA_WIDTH-1:0] entry_q [RRF_ENTRIES]; // architectural state

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < RRF_ENTRIES; i++)
      begin
        entry_q[i] <= '0; // architectural state starts at zero
      end
    end
    else
    begin
      for (int i = 0; i < RRF_ENTRIES; i++)
      begin
        if (entry_wen[i])
        begin
          entry_q[i] <= entry_sel1[i] ? wdata1 : wdata0; // port 1 wins
        end
      end
    end
  end

  // flatten for the read ports, entry 0 in the low bits
  genvar g;
  generate
    for (g = 0; g < RRF_ENTRIES; g++)
    begin : flat_gen
      assign entries_flat[g*DATA_WIDTH +: DATA_WIDTH] = entry_q[g];
    end
  endgenerate

endmodule

`default_nettype wire

// File: rrf_read_port.sv
// rrf read port: captures address and output enable, then drives true and inverted data
`timescale 1ns/1ps
`default_nettype none

module rrf_read_port
  import rrf_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)
(
  input  wire logic                              clk,
  input  wire logic                              rst,
  input  wire logic                              read_clk_en,
  input  wire rrf_addr_t                         addr,
  input  wire logic                              oe,
  input  wire logic [RRF_ENTRIES*DATA_WIDTH-1:0] entries_flat,
  output logic      [DATA_WIDTH-1:0]             data,
  output logic      [DATA_WIDTH-1:0]             data_n
);

  rrf_addr_t                     addr_q;   // captured read address
  logic                          oe_q;     // captured output enable
  logic [RRF_TILE_SEL_WIDTH-1:0] tile_sel;
  logic [RRF_IDX_WIDTH-1:0]      idx;
  logic [DATA_WIDTH-1:0]         tile_data [RRF_TILES];
  logic [DATA_WIDTH-1:0]         sel_data;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr_q <= '0;
      oe_q   <= 1'b1; // ports come up enabled on entry 0
    end
    else if (read_clk_en)
    begin
      addr_q <= addr;
      oe_q   <= oe;
    end
  end

  assign tile_sel = addr_q[RRF_ADDR_WIDTH-1 -: RRF_TILE_SEL_WIDTH];
  assign idx      = addr_q[RRF_IDX_WIDTH-1:0];

  // first level, same index picked in every tile
  always_comb
  begin
    for (int t = 0; t < RRF_TILES; t++)
    begin
      tile_data[t] = entries_flat[(t*RRF_TILE_ENTRIES + int'(idx))*DATA_WIDTH +: DATA_WIDTH];
    end
  end

  // second level, tile select from the upper bits
  assign sel_data = tile_data[tile_sel];

  // disabled port drives zero on both rails
  always_comb
  begin
    if (oe_q)
    begin
      data   = sel_data;
      data_n = ~sel_data;
    end
    else
    begin
      data   = '0;
      data_n = '0;
    end
  end

endmodule

`default_nettype wire

// File: rrf_top.sv
// rrf top: retirement register file with two write ports and three read ports
`timescale 1ns/1ps
`default_nettype none

module rrf_top
  import rrf_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  read_clk_en,

  // retire write ports
  input  wire rrf_addr_t             write0_addr,
  input  wire logic [DATA_WIDTH-1:0] write0_data,
  input  wire logic                  write0_wen,
  input  wire rrf_addr_t             write1_addr,
  input  wire logic [DATA_WIDTH-1:0] write1_data,
  input  wire logic                  write1_wen,

  // operand fetch read ports
  input  wire rrf_addr_t             read0_addr,
  input  wire logic                  read0_oe,
  output logic      [DATA_WIDTH-1:0] read0_data,
  output logic      [DATA_WIDTH-1:0] read0_data_n,
  input  wire rrf_addr_t             read1_addr,
  input  wire logic                  read1_oe,
  output logic      [DATA_WIDTH-1:0] read1_data,
  output logic      [DATA_WIDTH-1:0] read1_data_n,
  input  wire rrf_addr_t             read2_addr,
  input  wire logic                  read2_oe,
  output logic      [DATA_WIDTH-1:0] read2_data,
  output logic      [DATA_WIDTH-1:0] read2_data_n
);

  logic [RRF_ENTRIES-1:0]            entry_wen;
  logic [RRF_ENTRIES-1:0]            entry_sel1;
  logic [DATA_WIDTH-1:0]             wdata0;
  logic [DATA_WIDTH-1:0]             wdata1;
  logic [RRF_ENTRIES*DATA_WIDTH-1:0] entries_flat;

  rrf_write_decode #(.DATA_WIDTH(DATA_WIDTH)) write_decode_i (
    .write0_addr (write0_addr),
    .write0_data (write0_data),
    .write0_wen  (write0_wen),
    .write1_addr (write1_addr),
    .write1_data (write1_data),
    .write1_wen  (write1_wen),
    .entry_wen   (entry_wen),
    .entry_sel1  (entry_sel1),
    .wdata0      (wdata0),
    .wdata1      (wdata1)
  );

  rrf_entry_bank #(.DATA_WIDTH(DATA_WIDTH)) entry_bank_i (
    .clk          (clk),
    .rst          (rst),
    .entry_wen    (entry_wen),
    .entry_sel1   (entry_sel1),
    .wdata0       (wdata0),
    .wdata1       (wdata1),
    .entries_flat (entries_flat)
  );

  rrf_read_port #(.DATA_WIDTH(DATA_WIDTH)) read0_i (
    .clk          (clk),
    .rst          (rst),
    .read_clk_en  (read_clk_en),
    .addr         (read0_addr),
    .oe           (read0_oe),
    .entries_flat (entries_flat),
    .data         (read0_data),
    .data_n       (read0_data_n)
  );

  rrf_read_port #(.DATA_WIDTH(DATA_WIDTH)) read1_i (
    .clk          (clk),
    .rst          (rst),
    .read_clk_en  (read_clk_en),
    .addr         (read1_addr),
    .oe           (read1_oe),
    .entries_flat (entries_flat),
    .data         (read1_data),
    .data_n       (read1_data_n)
  );

  rrf_read_port #(.DATA_WIDTH(DATA_WIDTH)) read2_i (
    .clk          (clk),
    .rst          (rst),
    .read_clk_en  (read_clk_en),
    .addr         (read2_addr),
    .oe           (read2_oe),
    .entries_flat (entries_flat),
    .data         (read2_data),
    .data_n       (read2_data_n)
  );

endmodule

`default_nettype wire

// File: rrf_sva.sv
// rrf assertions: reset state, inverted rails and hold of the read outputs
`timescale 1ns/1ps
`default_nettype none

module rrf_sva #(
  parameter int DATA_WIDTH = 32
)
(
  input wire logic                  clk,
  input wire logic                  rst,
  input wire logic                  read_clk_en,
  input wire logic                  write0_wen,
  input wire logic                  write1_wen,
  input wire logic [DATA_WIDTH-1:0] read0_data,
  input wire logic [DATA_WIDTH-1:0] read0_data_n,
  input wire logic [DATA_WIDTH-1:0] read1_data,
  input wire logic [DATA_WIDTH-1:0] read1_data_n,
  input wire logic [DATA_WIDTH-1:0] read2_data,
  input wire logic [DATA_WIDTH-1:0] read2_data_n
);

  logic quiet; // no capture and no write on this edge
  assign quiet = !rst && !read_clk_en && !write0_wen && !write1_wen;

  rst_zero: assert property (@(posedge clk) rst |=> (read0_data | read1_data | read2_data) == '0)
    else $error("read data not zero after reset");

  inv0: assert property (@(posedge clk) disable iff (rst)
    read0_data != '0 |-> read0_data_n == ~read0_data)
    else $error("read0_data_n is not the inverse of read0_data");

  inv1: assert property (@(posedge clk) disable iff (rst)
    read1_data != '0 |-> read1_data_n == ~read1_data)
    else $error("read1_data_n is not the inverse of read1_data");

  inv2: assert property (@(posedge clk) disable iff (rst)
    read2_data != '0 |-> read2_data_n == ~read2_data)
    else $error("read2_data_n is not the inverse of read2_data");

  hold: assert property (@(posedge clk)
    quiet |=> $stable(read0_data) && $stable(read1_data) && $stable(read2_data))
    else $error("read data moved without a capture or a write");

endmodule

bind rrf_top rrf_sva #(.DATA_WIDTH(DATA_WIDTH)) sva_i (
  .clk          (clk),
  .rst          (rst),
  .read_clk_en  (read_clk_en),
  .write0_wen   (write0_wen),
  .write1_wen   (write1_wen),
  .read0_data   (read0_data),
  .read0_data_n (read0_data_n),
  .read1_data   (read1_data),
  .read1_data_n (read1_data_n),
  .read2_data   (read2_data),
  .read2_data_n (read2_data_n)
);

`default_nettype wire

// File: tb_rrf.sv
// rrf testbench: file-driven directed steps and a random sweep against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_rrf
  import rrf_pkg::*;
();

  localparam int DATA_WIDTH   = 32;
  localparam int REC_WORDS    = 17;  // words per record in the test data
  localparam int MAX_RECS     = 64;
  localparam int RAND_STEPS   = 200;
  localparam int SETTLE_LIMIT = 16;  // cycles allowed for the reset state to show

  logic                  clk;
  logic                  rst;
  logic                  read_clk_en;
  rrf_addr_t             write0_addr;
  logic [DATA_WIDTH-1:0] write0_data;
  logic                  write0_wen;
  rrf_addr_t             write1_addr;
  logic [DATA_WIDTH-1:0] write1_data;
  logic                  write1_wen;
  rrf_addr_t             read_addr   [3];
  logic                  read_oe     [3];
  logic [DATA_WIDTH-1:0] read_data   [3];
  logic [DATA_WIDTH-1:0] read_data_n [3];

  // reference model, entries plus the captured read state
  logic [DATA_WIDTH-1:0] model    [RRF_ENTRIES];
  rrf_addr_t             cap_addr [3];
  logic                  cap_oe   [3];

  // one step of stimulus
  rrf_addr_t             s_w0_addr;
  logic [DATA_WIDTH-1:0] s_w0_data;
  logic                  s_w0_wen;
  rrf_addr_t             s_w1_addr;
  logic [DATA_WIDTH-1:0] s_w1_data;
  logic                  s_w1_wen;
  logic                  s_rce;
  rrf_addr_t             s_raddr [3];
  logic                  s_roe   [3];
  logic [DATA_WIDTH-1:0] s_exp   [3];
  logic                  s_use_file; // random steps have no file values

  logic [31:0] tdata [MAX_RECS*REC_WORDS];
  int          errors;
  int          checks;
  int          test_errors;
  int          tests_run;
  int          tests_failed;

  initial clk = 1'b0;
  always #10 clk = ~clk; // 20 ns period

  rrf_top #(.DATA_WIDTH(DATA_WIDTH)) dut_i (
    .clk          (clk),
    .rst          (rst),
    .read_clk_en  (read_clk_en),
    .write0_addr  (write0_addr),
    .write0_data  (write0_data),
    .write0_wen   (write0_wen),
    .write1_addr  (write1_addr),
    .write1_data  (write1_data),
    .write1_wen   (write1_wen),
    .read0_addr   (read_addr[0]),
    .read0_oe     (read_oe[0]),
    .read0_data   (read_data[0]),
    .read0_data_n (read_data_n[0]),
    .read1_addr   (read_addr[1]),
    .read1_oe     (read_oe[1]),
    .read1_data   (read_data[1]),
    .read1_data_n (read_data_n[1]),
    .read2_addr   (read_addr[2]),
    .read2_oe     (read_oe[2]),
    .read2_data   (read_data[2]),
    .read2_data_n (read_data_n[2])
  );

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] actual,
                            input logic [DATA_WIDTH-1:0] file_exp,
                            input logic [DATA_WIDTH-1:0] model_exp);
    checks++;
    if (s_use_file && actual !== file_exp)
    begin
      $display("ERR %0t %s file expects %h, got %h", $time, name, file_exp, actual);
      errors++;
      test_errors++;
    end
    if (actual !== model_exp)
    begin
      $display("ERR %0t %s model expects %h, got %h", $time, name, model_exp, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_inverse(input string name, input logic [DATA_WIDTH-1:0] actual_n,
                               input logic [DATA_WIDTH-1:0] model_exp, input logic oe);
    logic [DATA_WIDTH-1:0] exp_n;
    exp_n = oe ? ~model_exp : '0; // both rails low on a disabled port
    checks++;
    if (actual_n !== exp_n)
    begin
      $display("ERR %0t %s expected %h, got %h", $time, name, exp_n, actual_n);
      errors++;
      test_errors++;
    end
  endtask

  task automatic close_test(input int num);
    tests_run++;
    if (test_errors > 0)
    begin
      tests_failed++;
    end
    $display("test %0d done, %0d errors", num, test_errors);
    test_errors = 0;
  endtask

  task automatic wait_reset_state();
    int cycles;
    bit ready;
    cycles = 0;
    ready  = 1'b0;
    while (!ready && cycles < SETTLE_LIMIT)
    begin
      @(negedge clk);
      cycles++;
      ready = 1'b1;
      for (int p = 0; p < 3; p++)
      begin
        if (read_data[p] !== '0 || read_data_n[p] !== '1)
        begin
          ready = 1'b0;
        end
      end
    end
    if (!ready)
    begin
      $display("timeout: read ports did not show the reset state within %0d cycles", cycles);
      errors++;
    end
  endtask

  task automatic load_record(input int base);
    s_w0_addr = rrf_addr_t'(tdata[base+1]);
    s_w0_data = tdata[base+2];
    s_w0_wen  = tdata[base+3][0];
    s_w1_addr = rrf_addr_t'(tdata[base+4]);
    s_w1_data = tdata[base+5];
    s_w1_wen  = tdata[base+6][0];
    s_rce     = tdata[base+7][0];
    for (int p = 0; p < 3; p++)
    begin
      s_raddr[p] = rrf_addr_t'(tdata[base+8+2*p]);
      s_roe[p]   = tdata[base+9+2*p][0];
      s_exp[p]   = tdata[base+14+p];
    end
    s_use_file = 1'b1;
  endtask

  task automatic random_step();
    logic [31:0] ctl;
    logic [31:0] adr;
    ctl = $urandom;
    adr = $urandom;
    s_w0_addr = ctl[4:0];
    s_w1_addr = ctl[9:5];
    s_w0_wen  = ctl[10];
    s_w1_wen  = ctl[11];
    s_rce     = ctl[12];
    if (ctl[15:13] == 3'd0)
    begin
      s_w1_addr = s_w0_addr; // collision now and then
    end
    s_w0_data = $urandom;
    s_w1_data = $urandom;
    for (int p = 0; p < 3; p++)
    begin
      s_raddr[p] = adr[5*p +: 5];
      s_roe[p]   = |ctl[16+2*p +: 2]; // mostly enabled
      s_exp[p]   = '0;
    end
    s_use_file = 1'b0;
  endtask

  task automatic run_step();
    logic [DATA_WIDTH-1:0] exp_m;
    @(posedge clk);
    write0_addr <= s_w0_addr;
    write0_data <= s_w0_data;
    write0_wen  <= s_w0_wen;
    write1_addr <= s_w1_addr;
    write1_data <= s_w1_data;
    write1_wen  <= s_w1_wen;
    read_clk_en <= s_rce;
    for (int p = 0; p < 3; p++)
    begin
      read_addr[p] <= s_raddr[p];
      read_oe[p]   <= s_roe[p];
    end
    @(posedge clk); // dut takes the step on this edge
    write0_wen  <= 1'b0;
    write1_wen  <= 1'b0;
    read_clk_en <= 1'b0;
    if (s_w0_wen)
    begin
      model[s_w0_addr] = s_w0_data;
    end
    if (s_w1_wen)
    begin
      model[s_w1_addr] = s_w1_data; // port 1 last, wins a collision
    end
    for (int p = 0; p < 3; p++)
    begin
      if (s_rce)
      begin
        cap_addr[p] = s_raddr[p];
        cap_oe[p]   = s_roe[p];
      end
    end
    @(negedge clk);
    for (int p = 0; p < 3; p++)
    begin
      exp_m = cap_oe[p] ? model[cap_addr[p]] : '0;
      check_data($sformatf("read%0d_data", p), read_data[p], s_exp[p], exp_m);
      check_inverse($sformatf("read%0d_data_n", p), read_data_n[p], exp_m, cap_oe[p]);
    end
  endtask

  initial
  begin
    logic [31:0] seed_ret;
    int          base;
    int          cur_test;
    seed_ret     = $urandom(32'h719f_ca83);
    errors       = 0;
    checks       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    read_clk_en  = 1'b0;
    write0_addr  = '0;
    write0_data  = '0;
    write0_wen   = 1'b0;
    write1_addr  = '0;
    write1_data  = '0;
    write1_wen   = 1'b0;
    for (int p = 0; p < 3; p++)
    begin
      read_addr[p] = '0;
      read_oe[p]   = 1'b1;
      cap_addr[p]  = '0;
      cap_oe[p]    = 1'b1; // ports leave reset enabled on entry 0
    end
    for (int i = 0; i < RRF_ENTRIES; i++)
    begin
      model[i] = '0;
    end
    for (int i = 0; i < MAX_RECS*REC_WORDS; i++)
    begin
      tdata[i] = '0; // test number 0 ends the list
    end
    $readmemh("rrf_testdata.txt", tdata);

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    wait_reset_state();

    cur_test = 0;
    for (int r = 0; r < MAX_RECS; r++)
    begin
      base = r * REC_WORDS;
      if (tdata[base] == 0)
      begin
        break;
      end
      if (cur_test != 0 && tdata[base] != cur_test)
      begin
        close_test(cur_test);
      end
      cur_test = tdata[base];
      load_record(base);
      run_step();
    end
    if (cur_test != 0)
    begin
      close_test(cur_test);
    end
    else
    begin
      $display("no records were read from the test data file");
      errors++;
    end

    // random sweep, model only
    for (int i = 0; i < RAND_STEPS; i++)
    begin
      random_step();
      run_step();
    end
    close_test(cur_test + 1);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rrf_testdata.txt
// rrf directed steps, one per line, all fields hex
// test w0_addr w0_data w0_wen w1_addr w1_data w1_wen read_clk_en
//   r0_addr r0_oe r1_addr r1_oe r2_addr r2_oe exp_r0 exp_r1 exp_r2
01 00 00000000 0 00 00000000 0 1 00 1 0f 1 1f 1 00000000 00000000 00000000
// fill every entry through alternating ports and read back
02 00 c0de0000 1 01 c0de0001 1 1 00 1 01 1 1e 1 c0de0000 c0de0001 00000000
02 03 c0de0003 1 02 c0de0002 1 1 02 1 03 1 00 1 c0de0002 c0de0003 c0de0000
02 04 c0de0004 1 05 c0de0005 1 1 04 1 05 1 02 1 c0de0004 c0de0005 c0de0002
02 07 c0de0007 1 06 c0de0006 1 1 06 1 07 1 04 1 c0de0006 c0de0007 c0de0004
02 08 c0de0008 1 09 c0de0009 1 1 08 1 09 1 06 1 c0de0008 c0de0009 c0de0006
02 0b c0de000b 1 0a c0de000a 1 1 0a 1 0b 1 08 1 c0de000a c0de000b c0de0008
02 0c c0de000c 1 0d c0de000d 1 1 0c 1 0d 1 0a 1 c0de000c c0de000d c0de000a
02 0f c0de000f 1 0e c0de000e 1 1 0e 1 0f 1 0c 1 c0de000e c0de000f c0de000c
02 10 c0de0010 1 11 c0de0011 1 1 10 1 11 1 0e 1 c0de0010 c0de0011 c0de000e
02 13 c0de0013 1 12 c0de0012 1 1 12 1 13 1 10 1 c0de0012 c0de0013 c0de0010
02 14 c0de0014 1 15 c0de0015 1 1 14 1 15 1 12 1 c0de0014 c0de0015 c0de0012
02 17 c0de0017 1 16 c0de0016 1 1 16 1 17 1 14 1 c0de0016 c0de0017 c0de0014
02 18 c0de0018 1 19 c0de0019 1 1 18 1 19 1 16 1 c0de0018 c0de0019 c0de0016
02 1b c0de001b 1 1a c0de001a 1 1 1a 1 1b 1 18 1 c0de001a c0de001b c0de0018
02 1c c0de001c 1 1d c0de001d 1 1 1c 1 1d 1 1a 1 c0de001c c0de001d c0de001a
02 1f c0de001f 1 1e c0de001e 1 1 1e 1 1f 1 1c 1 c0de001e c0de001f c0de001c
// same entry on both ports, then two different entries
03 05 11111111 1 05 22222222 1 1 05 1 04 1 06 1 22222222 c0de0004 c0de0006
03 14 33333333 1 15 44444444 1 1 14 1 15 1 05 1 33333333 44444444 22222222
// read_clk_en low, new addresses ignored, write shows through
04 00 00000000 0 00 00000000 0 0 00 1 01 1 02 1 33333333 44444444 22222222
04 15 55555555 1 00 00000000 0 0 03 1 04 1 05 1 33333333 55555555 22222222
// output enable off on ports 0 and 2, then back on
05 00 00000000 0 00 00000000 0 1 0a 0 0b 1 0c 0 00000000 c0de000b 00000000
05 00 00000000 0 00 00000000 0 1 0a 1 0b 1 0c 1 c0de000a c0de000b c0de000c

// File: sim.f
rrf_pkg.sv
rrf_write_decode.sv
rrf_entry_bank.sv
rrf_read_port.sv
rrf_top.sv
rrf_sva.sv
tb_rrf.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the rrf testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_rrf \
  --Mdir "$build_dir" -o tb_rrf_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/tb_rrf_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "^Testbench passed$" "$log_file"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail"
exit 1
